// ==== sim.f ====
+incdir+.
btn_pkg.sv
btn_ctrl_regs.sv
btn_hit_test.sv
btn_painter.sv
button_overlay.sv
button_overlay_sva.sv
tb_button_overlay.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_button_overlay
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED
SOURCES   := $(wildcard *.sv) $(wildcard *.svh) button_overlay_input.txt

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== button_overlay_input.txt ====
// op addr data strb hcount vcount rgb_in expect resp
// op 1 write, 2 read, 3 writes data as control word then checks one pixel, 0 ends
3 0 00000001 F 156 29C 123 F00 0
3 0 00000001 F 1BA 2CD 123 123 0
3 0 00000001 F 156 2CE 4A7 4A7 0
3 0 00000031 F 1B9 2CD 123 AAA 0
3 0 00000002 F 231 2CD 123 00F 0
3 0 00000002 F 246 29C 123 0F0 0
3 0 00000002 F 2AA 2A0 5C3 5C3 0
3 0 00000102 F 1CE 29C 123 AAA 0
3 0 00000002 F 156 29C 123 123 0
3 0 00000000 F 1A6 172 123 AAA 0
3 0 00000200 F 21D 1AD 123 F72 0
3 0 00000200 F 1A5 172 123 123 0
3 0 00000230 F 1A6 172 123 AAA 0
3 0 00000204 F 200 190 123 F72 0
3 0 00000201 F 200 190 123 123 0
3 0 00000036 F 135 1AD 123 43F 0
3 0 00000006 F 2C9 172 123 123 0
1 0 FFFFFFFF F 000 000 000 000 0
2 0 00000000 0 000 000 000 00000337 0
1 4 00000000 F 000 000 000 000 2
2 0 00000000 0 000 000 000 00000337 0
2 8 00000000 0 000 000 000 00000000 2
1 0 00000305 1 000 000 000 000 0
2 0 00000000 0 000 000 000 00000305 0
0 0 00000000 0 000 000 000 000 0

// ==== tb_button_overlay.sv ====
`timescale 1ns/1ps
`include "btn_cfg.svh"

module tb_button_overlay;

    localparam int NCOL      = 9;    // Words per vector line
    localparam int VEC_MAX   = 64;
    localparam int RAND_BLKS = 7;    // One block per phase
    localparam int RAND_PIX  = 24;
    localparam int NUM_RAND  = RAND_BLKS * RAND_PIX;

    logic               clk;
    logic               rst;
    btn_pkg::vga_bus_t  vga_in;
    btn_pkg::vga_bus_t  vga_out;
    btn_pkg::axil_req_t axil_req;
    btn_pkg::axil_rsp_t axil_rsp;

    logic [31:0] vec_mem [0:VEC_MAX*NCOL-1];
    logic [31:0] lcg_state = 32'h0c08_a0e5;
    int          num_vec;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    button_overlay button_overlay_i (
        .clk      (clk),
        .rst      (rst),
        .vga_in   (vga_in),
        .vga_out  (vga_out),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            stop_on_failure($sformatf("Timeout, run not finished after %0d cycles", cycle_count));
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_rgb(input string name, input btn_pkg::rgb_t got,
                             input btn_pkg::rgb_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bus(input string name, input btn_pkg::vga_bus_t got,
                             input btn_pkg::vga_bus_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input btn_pkg::axil_resp_t got,
                              input btn_pkg::axil_resp_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_data(input string name, input btn_pkg::axil_data_t got,
                              input btn_pkg::axil_data_t exp);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic axi_write(input btn_pkg::axil_addr_t addr, input btn_pkg::axil_data_t data,
                             input btn_pkg::axil_strb_t strb, output btn_pkg::axil_resp_t resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.bready  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        check_flag("wready", axil_rsp.wready, 1'b1);
        @(posedge clk);                  // Address and data accepted here
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        resp = axil_rsp.bresp;
        @(posedge clk);
        axil_req.bready <= 1'b1;         // Response sat one cycle with bready low
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input btn_pkg::axil_addr_t addr, output btn_pkg::axil_data_t data,
                            output btn_pkg::axil_resp_t resp);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        axil_req.rready <= 1'b1;         // Data sat one cycle with rready low
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic write_ctrl(input btn_pkg::axil_data_t data);
        btn_pkg::axil_resp_t resp;
        axi_write(`BTN_CTRL_ADDR, data, 4'hF, resp);
        check_resp("bresp", resp, btn_pkg::resp_okay);
    endtask

    // Byte 1 alone changes the flags and leaves phase and player alone
    task automatic test_partial_strobes();
        btn_pkg::axil_data_t rdata;
        btn_pkg::axil_resp_t resp;
        write_ctrl(32'h0000_0125);
        axi_write(`BTN_CTRL_ADDR, 32'hFFFF_02FA, 4'h2, resp);
        check_resp("bresp", resp, btn_pkg::resp_okay);
        axi_read(`BTN_CTRL_ADDR, rdata, resp);
        check_data("rdata", rdata, 32'h0000_0225);
        check_resp("rresp", resp, btn_pkg::resp_okay);
    endtask

    // Fixed two-cycle video latency
    task automatic apply_pixel(input btn_pkg::hcount_t h, input btn_pkg::vcount_t v,
                               input btn_pkg::rgb_t rgb, input btn_pkg::rgb_t exp_rgb);
        btn_pkg::vga_bus_t pix;
        btn_pkg::vga_bus_t exp_bus;
        pix        = '0;
        pix.hcount = h;
        pix.vcount = v;
        pix.hsync  = h[0];
        pix.vsync  = v[0];
        pix.rgb    = rgb;
        exp_bus     = pix;
        exp_bus.rgb = exp_rgb;
        @(posedge clk);
        vga_in <= pix;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_rgb("vga_out.rgb", vga_out.rgb, exp_rgb);
        check_bus("vga_out", vga_out, exp_bus);
    endtask

    // One pixel per cycle, all above the highest button row
    task automatic stream_random(input int n);
        btn_pkg::vga_bus_t hist [$];
        btn_pkg::vga_bus_t pix;
        logic [31:0]       r;
        int                i;
        for (i = 0; i < n + 2; i++) begin
            r          = lcg_next();
            pix.hcount = r[10:0];
            pix.vcount = btn_pkg::vcount_t'(r[26:16] % `BTN_PL_Y);
            pix.hsync  = r[27];
            pix.vsync  = r[28];
            pix.hblnk  = r[29];
            pix.vblnk  = r[30];
            pix.rgb    = btn_pkg::rgb_t'(lcg_next());
            @(posedge clk);
            vga_in <= pix;
            hist.push_back(pix);
            @(negedge clk);
            if (i >= 2) check_bus("vga_out", vga_out, hist.pop_front());
        end
    endtask

    task automatic run_vector(input int idx);
        logic [31:0]         op;
        btn_pkg::axil_resp_t resp;
        btn_pkg::axil_data_t rdata;
        int                  base;
        base = idx * NCOL;
        op   = vec_mem[base];
        case (op)
            32'd1: begin
                axi_write(vec_mem[base+1][3:0], vec_mem[base+2], vec_mem[base+3][3:0], resp);
                check_resp("bresp", resp, vec_mem[base+8][1:0]);
            end
            32'd2: begin
                axi_read(vec_mem[base+1][3:0], rdata, resp);
                check_data("rdata", rdata, vec_mem[base+7]);
                check_resp("rresp", resp, vec_mem[base+8][1:0]);
            end
            32'd3: begin
                write_ctrl(vec_mem[base+2]);
                apply_pixel(vec_mem[base+4][10:0], vec_mem[base+5][10:0],
                            vec_mem[base+6][11:0], vec_mem[base+7][11:0]);
            end
            default: stop_on_failure($sformatf("Unknown opcode %0d in vector %0d", op, idx));
        endcase
    endtask

    initial begin
        rst      <= 1'b1;
        vga_in   <= '1;                  // Nonzero so the cleared output shows the reset
        axil_req <= '0;
        foreach (vec_mem[i]) vec_mem[i] = '0;
        $readmemh("button_overlay_input.txt", vec_mem);
        num_vec = 0;
        while (num_vec < VEC_MAX && vec_mem[num_vec*NCOL] != 32'd0) num_vec++;
        timeout_limit = (num_vec + NUM_RAND) * 10 + 100;
        if (num_vec == 0) stop_on_failure("No vectors found in button_overlay_input.txt");

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bus("vga_out", vga_out, '0);
        check_flag("bvalid", axil_rsp.bvalid, 1'b0);
        check_flag("rvalid", axil_rsp.rvalid, 1'b0);

        for (int v = 0; v < num_vec; v++) run_vector(v);

        test_partial_strobes();

        for (int b = 0; b < RAND_BLKS; b++) begin
            write_ctrl((lcg_next() & 32'h0000_0330) | 32'(b));
            stream_random(RAND_PIX);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== button_overlay_sva.sv ====
`timescale 1ns/1ps

module button_overlay_sva (
    input logic               clk,
    input logic               rst,
    input btn_pkg::axil_req_t axil_req,
    input btn_pkg::axil_rsp_t axil_rsp
);

    property bvalid_hold;
        @(posedge clk) disable iff (rst)
            axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp);
    endproperty

    property rvalid_hold;
        @(posedge clk) disable iff (rst)
            axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata);
    endproperty

    // No write response can be pending straight out of reset
    property bvalid_low_after_reset;
        @(posedge clk) rst |=> !axil_rsp.bvalid;
    endproperty

    a_bvalid_hold: assert property (bvalid_hold) else $error("bvalid dropped before bready");
    a_rvalid_hold: assert property (rvalid_hold) else $error("rvalid dropped before rready");
    a_reset_state: assert property (bvalid_low_after_reset) else $error("bvalid high after reset");

endmodule

bind btn_ctrl_regs button_overlay_sva sva_i (
    .clk      (clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
);

// ==== button_overlay.sv ====
`timescale 1ns/1ps

module button_overlay (
    input  logic               clk,
    input  logic               rst,
    input  btn_pkg::vga_bus_t  vga_in,
    output btn_pkg::vga_bus_t  vga_out,
    input  btn_pkg::axil_req_t axil_req,
    output btn_pkg::axil_rsp_t axil_rsp
);

    btn_pkg::btn_ctrl_t ctrl;
    btn_pkg::vga_bus_t  vga_mid;
    btn_pkg::btn_id_t   hit;

    btn_ctrl_regs u_ctrl_regs (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .ctrl     (ctrl)
    );

    // Stage 1 finds the button, stage 2 paints it
    btn_hit_test u_hit_test (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_in),
        .phase   (ctrl.phase),
        .vga_mid (vga_mid),
        .hit     (hit)
    );

    btn_painter u_painter (
        .clk             (clk),
        .rst             (rst),
        .vga_mid         (vga_mid),
        .hit             (hit),
        .player          (ctrl.player),
        .deal_wait       (ctrl.deal_wait),
        .dealer_finished (ctrl.dealer_finished),
        .vga_out         (vga_out)
    );

endmodule

// ==== btn_painter.sv ====
`timescale 1ns/1ps
`include "btn_cfg.svh"

module btn_painter (
    input  logic                 clk,
    input  logic                 rst,
    input  btn_pkg::vga_bus_t    vga_mid,
    input  btn_pkg::btn_id_t     hit,
    input  btn_pkg::player_sel_t player,
    input  logic                 deal_wait,
    input  logic                 dealer_finished,
    output btn_pkg::vga_bus_t    vga_out
);

    logic              no_player;
    btn_pkg::rgb_t     fill;
    btn_pkg::vga_bus_t vga_nxt;

    assign no_player = (player == btn_pkg::player_none);

    always_comb begin
        case (hit)
            btn_pkg::btn_deal:    fill = no_player ? `BTN_COL_GREY : `BTN_COL_DEAL;
            btn_pkg::btn_hit:     fill = deal_wait ? `BTN_COL_GREY : `BTN_COL_HIT;
            btn_pkg::btn_stand:   fill = deal_wait ? `BTN_COL_GREY : `BTN_COL_STAND;
            btn_pkg::btn_start: begin
                // Start stays disabled until the dealer is done and someone can play
                if (!dealer_finished || no_player) begin
                    fill = `BTN_COL_GREY;
                end else begin
                    fill = `BTN_COL_START;
                end
            end
            btn_pkg::btn_player1,
            btn_pkg::btn_player2: fill = `BTN_COL_PLAYER;
            default:              fill = vga_mid.rgb;   // Outside any visible button
        endcase
    end

    always_comb begin
        vga_nxt     = vga_mid;
        vga_nxt.rgb = fill;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

endmodule

// ==== btn_hit_test.sv ====
`timescale 1ns/1ps
`include "btn_cfg.svh"

module btn_hit_test (
    input  logic                 clk,
    input  logic                 rst,
    input  btn_pkg::vga_bus_t    vga_in,
    input  btn_pkg::game_phase_t phase,
    output btn_pkg::vga_bus_t    vga_mid,
    output btn_pkg::btn_id_t     hit
);

    logic             show_deal;
    logic             show_turn;
    logic             show_start;
    logic             show_pick;
    btn_pkg::btn_id_t hit_nxt;

    // Left and top edges inclusive, right and bottom exclusive
    function automatic logic in_rect(
        input btn_pkg::hcount_t hc,
        input btn_pkg::vcount_t vc,
        input int               x,
        input int               y,
        input int               w,
        input int               h
    );
        return (int'(hc) >= x) && (int'(hc) < x + w) &&
               (int'(vc) >= y) && (int'(vc) < y + h);
    endfunction

    assign show_deal  = (phase == btn_pkg::st_deal);
    assign show_turn  = (phase == btn_pkg::st_turn);
    assign show_start = (phase inside {btn_pkg::st_start, btn_pkg::st_dealer,
                                       btn_pkg::st_result, btn_pkg::st_round_end});
    assign show_pick  = (phase == btn_pkg::st_pick);

    always_comb begin
        if (show_deal && in_rect(vga_in.hcount, vga_in.vcount,
                                 `BTN1_X, `BTN_ROW_Y, `BTN_ROW_W, `BTN_ROW_H)) begin
            hit_nxt = btn_pkg::btn_deal;
        end else if (show_turn && in_rect(vga_in.hcount, vga_in.vcount,
                                          `BTN2_X, `BTN_ROW_Y, `BTN_ROW_W, `BTN_ROW_H)) begin
            hit_nxt = btn_pkg::btn_hit;
        end else if (show_turn && in_rect(vga_in.hcount, vga_in.vcount,
                                          `BTN3_X, `BTN_ROW_Y, `BTN_ROW_W, `BTN_ROW_H)) begin
            hit_nxt = btn_pkg::btn_stand;
        end else if (show_start && in_rect(vga_in.hcount, vga_in.vcount,
                                           `BTN_CTR_X, `BTN_CTR_Y, `BTN_CTR_W, `BTN_CTR_H)) begin
            hit_nxt = btn_pkg::btn_start;
        end else if (show_pick && in_rect(vga_in.hcount, vga_in.vcount,
                                          `BTN_P1_X, `BTN_PL_Y, `BTN_PL_W, `BTN_PL_H)) begin
            hit_nxt = btn_pkg::btn_player1;
        end else if (show_pick && in_rect(vga_in.hcount, vga_in.vcount,
                                          `BTN_P2_X, `BTN_PL_Y, `BTN_PL_W, `BTN_PL_H)) begin
            hit_nxt = btn_pkg::btn_player2;
        end else begin
            hit_nxt = btn_pkg::btn_none;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_mid <= '0;
            hit     <= btn_pkg::btn_none;
        end else begin
            vga_mid <= vga_in;
            hit     <= hit_nxt;   // Travels alongside its pixel
        end
    end

endmodule

// ==== btn_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "btn_cfg.svh"

module btn_ctrl_regs (
    input  logic               clk,
    input  logic               rst,
    input  btn_pkg::axil_req_t axil_req,
    output btn_pkg::axil_rsp_t axil_rsp,
    output btn_pkg::btn_ctrl_t ctrl
);

    logic                wr_fire;
    logic                rd_fire;
    logic                wr_addr_ok;
    logic                rd_addr_ok;
    logic                bvalid;
    logic                rvalid;
    btn_pkg::axil_resp_t bresp;
    btn_pkg::axil_resp_t rresp;
    btn_pkg::axil_data_t rdata;
    btn_pkg::axil_data_t ctrl_word;

    // Address and data are taken together, one outstanding response per channel
    assign wr_fire    = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_fire    = axil_req.arvalid && !rvalid;
    assign wr_addr_ok = (axil_req.awaddr == `BTN_CTRL_ADDR);
    assign rd_addr_ok = (axil_req.araddr == `BTN_CTRL_ADDR);

    always_comb begin
        ctrl_word      = '0;              // Unused bits read as zero
        ctrl_word[2:0] = ctrl.phase;
        ctrl_word[5:4] = ctrl.player;
        ctrl_word[8]   = ctrl.deal_wait;
        ctrl_word[9]   = ctrl.dealer_finished;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (wr_fire && wr_addr_ok) begin
            if (axil_req.wstrb[0]) begin
                ctrl.phase  <= btn_pkg::game_phase_t'(axil_req.wdata[2:0]);
                ctrl.player <= axil_req.wdata[5:4];
            end
            if (axil_req.wstrb[1]) begin
                ctrl.deal_wait       <= axil_req.wdata[8];
                ctrl.dealer_finished <= axil_req.wdata[9];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_addr_ok ? btn_pkg::resp_okay : btn_pkg::resp_slverr;
        end
        if (rd_fire) begin
            rdata <= rd_addr_ok ? ctrl_word : '0;
            rresp <= rd_addr_ok ? btn_pkg::resp_okay : btn_pkg::resp_slverr;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = rd_fire;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

endmodule

// ==== btn_pkg.sv ====
`include "btn_cfg.svh"

package btn_pkg;

    typedef logic [`BTN_HCOUNT_W-1:0] hcount_t;
    typedef logic [`BTN_VCOUNT_W-1:0] vcount_t;
    typedef logic [`BTN_RGB_W-1:0]    rgb_t;
    typedef logic [1:0]               player_sel_t;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    localparam player_sel_t player_none = 2'd3;  // No player may act
    localparam axil_resp_t  resp_okay   = 2'b00;
    localparam axil_resp_t  resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        st_start     = 3'd0,
        st_deal      = 3'd1,
        st_turn      = 3'd2,
        st_dealer    = 3'd3,
        st_result    = 3'd4,
        st_round_end = 3'd5,
        st_pick      = 3'd6
    } game_phase_t;

    typedef enum logic [2:0] {
        btn_none,
        btn_deal,
        btn_hit,
        btn_stand,
        btn_start,
        btn_player1,
        btn_player2
    } btn_id_t;

    typedef struct packed {
        vcount_t vcount;
        logic    vsync;
        logic    vblnk;
        hcount_t hcount;
        logic    hsync;
        logic    hblnk;
        rgb_t    rgb;
    } vga_bus_t;

    typedef struct packed {
        game_phase_t phase;
        player_sel_t player;
        logic        deal_wait;
        logic        dealer_finished;
    } btn_ctrl_t;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage

// ==== btn_cfg.svh ====
`ifndef BTN_CFG_SVH
`define BTN_CFG_SVH

// Pixel counter and colour widths
`define BTN_HCOUNT_W    11
`define BTN_VCOUNT_W    11
`define BTN_RGB_W       12

// Bottom row of three buttons
`define BTN_ROW_Y       668
`define BTN_ROW_W       100
`define BTN_ROW_H       50
`define BTN1_X          342      // Deal
`define BTN2_X          462      // Hit
`define BTN3_X          582      // Stand

// Central start button
`define BTN_CTR_X       422
`define BTN_CTR_Y       370
`define BTN_CTR_W       120
`define BTN_CTR_H       60

// Player select buttons share row and size
`define BTN_P1_X        150
`define BTN_P2_X        714
`define BTN_PL_Y        370
`define BTN_PL_W        160
`define BTN_PL_H        60

// Fill colours, 4-4-4
`define BTN_COL_GREY    12'hAAA
`define BTN_COL_DEAL    12'hF00
`define BTN_COL_HIT     12'h00F
`define BTN_COL_STAND   12'h0F0
`define BTN_COL_START   12'hF72
`define BTN_COL_PLAYER  12'h43F

// Byte address of the control register
`define BTN_CTRL_ADDR   4'h0

`endif
